// File: Makefile
TOP = tb_mm_engine

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f mm_engine_top.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: hdl/mm_engine_top.sv
// Matrix-vector engine top
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_engine_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  logic                            x_valid_i,
  input  mm_pkg::row_cnt_t                rows_i,
  input  mm_pkg::depth_cnt_t              cols_i,
  input  logic [`MM_DEPTH*`MM_ELEM_W-1:0] x_data_i,
  input  mm_pkg::elem_t [`MM_H-1:0]       coef_i,
  output logic                            busy_o,
  output logic                            done_o,
  output mm_pkg::acc_t [`MM_W-1:0]        z_o
);
  import mm_pkg::*;

  logic                          clear;
  logic                          load;
  logic                          d_shift; // Also the accumulate enable
  logic                          full;
  logic                          empty;
  row_cnt_t                      rows_lftovr;
  depth_cnt_t                    cols_lftovr;
  elem_t [`MM_W-1:0][`MM_H-1:0]  slice;

  mm_scheduler mm_scheduler_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .x_valid_i     (x_valid_i),
    .full_i        (full),
    .empty_i       (empty),
    .rows_i        (rows_i),
    .cols_i        (cols_i),
    .clear_o       (clear),
    .load_o        (load),
    .d_shift_o     (d_shift),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .rows_lftovr_o (rows_lftovr),
    .cols_lftovr_o (cols_lftovr)
  );

  mm_x_buffer mm_x_buffer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .load_i        (load),
    .d_shift_i     (d_shift),
    .rows_lftovr_i (rows_lftovr),
    .cols_lftovr_i (cols_lftovr),
    .x_data_i      (x_data_i),
    .slice_o       (slice),
    .full_o        (full),
    .empty_o       (empty)
  );

  mm_pe_array mm_pe_array_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear),
    .acc_en_i (d_shift),
    .slice_i  (slice),
    .coef_i   (coef_i),
    .z_o      (z_o)
  );

endmodule

// File: hdl/mm_macros.svh
// Engine sizing macros
`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

// Width of one X or coefficient element
`define MM_ELEM_W 8

`define MM_H 2 // Elements per depth slice, PE columns
`define MM_W 4 // Rows held in the buffer, PE rows
`define MM_D 4 // Slices per row

// Total elements in one X row
`define MM_DEPTH (`MM_H * `MM_D)

// Row accumulator, leaves headroom over MM_DEPTH products of 16 bits
`define MM_ACC_W 20

`endif

// File: hdl/mm_pe_array.sv
// Multiply-accumulate array
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_pe_array (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 acc_en_i,
  input  mm_pkg::elem_t [`MM_W-1:0][`MM_H-1:0] slice_i,
  input  mm_pkg::elem_t [`MM_H-1:0]            coef_i,
  output mm_pkg::acc_t  [`MM_W-1:0]            z_o
);
  import mm_pkg::*;

  acc_t [`MM_W-1:0][`MM_H-1:0] prod;     // One product per PE
  acc_t [`MM_W-1:0]            row_sum;
  acc_t [`MM_W-1:0]            z_q;

  always_comb begin : pe_mult
    for (int w = 0; w < `MM_W; w++) begin
      for (int h = 0; h < `MM_H; h++) begin
        // Lane h shares one coefficient down the column
        prod[w][h] = acc_t'(slice_i[w][h]) * acc_t'(coef_i[h]);
      end
    end
  end

  // Reduce each row across its lanes
  always_comb begin : row_reduce
    for (int w = 0; w < `MM_W; w++) begin
      row_sum[w] = '0;
      for (int h = 0; h < `MM_H; h++) begin
        row_sum[w] = row_sum[w] + prod[w][h];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : accumulate
    if (!rst_ni) begin
      z_q <= '0;
    end else if (clear_i) begin
      z_q <= '0; // New tile
    end else if (acc_en_i) begin
      for (int w = 0; w < `MM_W; w++) begin
        z_q[w] <= z_q[w] + row_sum[w];
      end
    end
  end

  assign z_o = z_q; // Held until the next clear

endmodule

// File: hdl/mm_pkg.sv
// Matrix engine types
`include "mm_macros.svh"

package mm_pkg;

  typedef logic [`MM_ELEM_W-1:0] elem_t; // One X or coefficient element
  typedef logic [`MM_ACC_W-1:0]  acc_t;  // One row accumulator

  // Counters include their upper bound
  typedef logic [$clog2(`MM_W+1)-1:0]     row_cnt_t;
  typedef logic [$clog2(`MM_DEPTH+1)-1:0] depth_cnt_t;
  typedef logic [$clog2(`MM_D+1)-1:0]     slot_cnt_t;

  // Tile sequencing
  typedef enum logic [1:0] {
    IDLE,    // Waiting for start
    LOAD,    // Rows streaming into the buffer
    COMPUTE, // One slice per cycle into the array
    FINISH   // Done pulse
  } sched_state_e;

endpackage

// File: hdl/mm_scheduler.sv
// Tile scheduler
`timescale 1ns/1ps

module mm_scheduler (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  logic               x_valid_i,
  input  logic               full_i,
  input  logic               empty_i,
  input  mm_pkg::row_cnt_t   rows_i,
  input  mm_pkg::depth_cnt_t cols_i,
  output logic               clear_o,
  output logic               load_o,
  output logic               d_shift_o,
  output logic               busy_o,
  output logic               done_o,
  output mm_pkg::row_cnt_t   rows_lftovr_o,
  output mm_pkg::depth_cnt_t cols_lftovr_o
);
  import mm_pkg::*;

  sched_state_e state_q;
  sched_state_e state_d;
  row_cnt_t     rows_q;
  depth_cnt_t   cols_q;
  logic         clear_q;
  logic         start_ok;

  assign start_ok = start_i && (state_q == IDLE); // Start ignored while busy

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_ok) state_d = LOAD;
      LOAD:    if (full_i) state_d = COMPUTE;
      COMPUTE: if (empty_i) state_d = FINISH;
      FINISH:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= IDLE;
      rows_q  <= '0;
      cols_q  <= '0;
      clear_q <= 1'b0;
    end else begin
      state_q <= state_d;
      clear_q <= start_ok;
      if (start_ok) begin
        rows_q <= rows_i; // Held for the whole tile
        cols_q <= cols_i;
      end
    end
  end

  // Strobes past the row limit are dropped
  assign load_o    = (state_q == LOAD) && x_valid_i && !full_i;
  assign d_shift_o = (state_q == COMPUTE) && !empty_i;

  assign clear_o       = clear_q;
  assign busy_o        = (state_q != IDLE);
  assign done_o        = (state_q == FINISH);
  assign rows_lftovr_o = rows_q;
  assign cols_lftovr_o = cols_q;

  // One done per tile
  assert property (@(posedge clk_i) disable iff (!rst_ni) done_o |=> !done_o)
    else $error("scheduler: done held for two cycles");

endmodule

// File: hdl/mm_x_buffer.sv
// X operand buffer
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_x_buffer (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 load_i,
  input  logic                                 d_shift_i,
  input  mm_pkg::row_cnt_t                     rows_lftovr_i,
  input  mm_pkg::depth_cnt_t                   cols_lftovr_i,
  input  logic [`MM_DEPTH*`MM_ELEM_W-1:0]      x_data_i,
  output mm_pkg::elem_t [`MM_W-1:0][`MM_H-1:0] slice_o,
  output logic                                 full_o,
  output logic                                 empty_o
);
  import mm_pkg::*;

  elem_t [`MM_D-1:0][`MM_W-1:0][`MM_H-1:0] x_q; // Slot 0 faces the array

  row_cnt_t                  w_index;
  row_cnt_t                  w_limit;
  logic [$clog2(`MM_W)-1:0]  wr_row;
  depth_cnt_t                eff_depth;
  depth_cnt_t                depth_rnd;
  slot_cnt_t                 slots;
  slot_cnt_t                 s_cnt;

  // Leftover of zero or out of range means a full tile
  assign w_limit = (rows_lftovr_i == '0 || rows_lftovr_i > row_cnt_t'(`MM_W)) ?
                   row_cnt_t'(`MM_W) : rows_lftovr_i;
  assign eff_depth = (cols_lftovr_i == '0 || cols_lftovr_i > depth_cnt_t'(`MM_DEPTH)) ?
                     depth_cnt_t'(`MM_DEPTH) : cols_lftovr_i;

  // Slices holding valid data, rounded up
  assign depth_rnd = eff_depth + depth_cnt_t'(`MM_H - 1);
  assign slots     = slot_cnt_t'(depth_rnd / depth_cnt_t'(`MM_H));

  // A load in the clear cycle lands in row 0
  assign wr_row = clear_i ? '0 : w_index[$clog2(`MM_W)-1:0];

  always_ff @(posedge clk_i) begin : storage
    if (clear_i) begin
      x_q <= '0;
    end
    if (load_i) begin
      for (int d = 0; d < `MM_D; d++) begin
        for (int h = 0; h < `MM_H; h++) begin
          // Tail past the valid depth is padded with zero
          x_q[d][wr_row][h] <= ((d * `MM_H + h) < int'(eff_depth)) ?
                               x_data_i[(d * `MM_H + h) * `MM_ELEM_W +: `MM_ELEM_W] : '0;
        end
      end
    end else if (d_shift_i) begin
      for (int d = 0; d < `MM_D - 1; d++) begin
        x_q[d] <= x_q[d+1]; // Whole slice moves toward slot 0
      end
      x_q[`MM_D-1] <= '0;
    end
  end

  // Rows loaded so far
  always_ff @(posedge clk_i or negedge rst_ni) begin : row_counter
    if (!rst_ni) begin
      w_index <= '0;
    end else if (clear_i) begin
      w_index <= load_i ? row_cnt_t'(1) : '0;
    end else if (full_o) begin
      w_index <= '0; // Ready for the next tile
    end else if (load_i) begin
      w_index <= w_index + row_cnt_t'(1);
    end
  end

  assign full_o = (w_index == w_limit);

  // Depth shifts so far
  always_ff @(posedge clk_i or negedge rst_ni) begin : shift_counter
    if (!rst_ni) begin
      s_cnt <= '0;
    end else if (clear_i || empty_o) begin
      s_cnt <= '0;
    end else if (d_shift_i) begin
      s_cnt <= s_cnt + slot_cnt_t'(1);
    end
  end

  assign empty_o = (s_cnt == slots);

  assign slice_o = x_q[0];

  // Scheduler keeps the load and compute phases apart
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(load_i && d_shift_i))
    else $error("x buffer: load and depth shift in the same cycle");

  // Loading stops at the row limit
  assert property (@(posedge clk_i) disable iff (!rst_ni) w_index <= row_cnt_t'(`MM_W))
    else $error("x buffer: row index past MM_W");

endmodule

// File: mm_engine_top.f
+incdir+hdl
hdl/mm_pkg.sv
hdl/mm_x_buffer.sv
hdl/mm_scheduler.sv
hdl/mm_pe_array.sv
hdl/mm_engine_top.sv
tb/tb_mm_engine.sv

// File: tb/tb_mm_engine.sv
// Matrix engine testbench
`timescale 1ns/1ps
`include "mm_macros.svh"

module tb_mm_engine;
  import mm_pkg::*;

  localparam int N_JOBS      = 33;              // Directed and random jobs together
  localparam int CYCLE_LIMIT = N_JOBS * 40 + 100;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            start_i;
  logic                            x_valid_i;
  row_cnt_t                        rows_i;
  depth_cnt_t                      cols_i;
  logic [`MM_DEPTH*`MM_ELEM_W-1:0] x_data_i;
  elem_t [`MM_H-1:0]               coef_i;
  logic                            busy_o;
  logic                            done_o;
  acc_t [`MM_W-1:0]                z_o;

  // Job state shared with the checker
  logic [`MM_DEPTH*`MM_ELEM_W-1:0] x_rows [`MM_W];
  int                              job_coef [`MM_H];
  int                              job_rows;
  int                              job_cols;
  string                           test_name;
  acc_t                            held_z [`MM_W];
  bit                              held_valid;
  bit                              start_seen;
  int                              jobs_started;
  int                              jobs_done;
  int                              error_cnt;
  int                              check_cnt;
  int                              cycle_cnt;
  logic [31:0]                     lfsr_q;

  mm_engine_top mm_engine_top_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (start_i),
    .x_valid_i (x_valid_i),
    .rows_i    (rows_i),
    .cols_i    (cols_i),
    .x_data_i  (x_data_i),
    .coef_i    (coef_i),
    .busy_o    (busy_o),
    .done_o    (done_o),
    .z_o       (z_o)
  );

  always #5 clk_i = ~clk_i;

  // Fibonacci LFSR on taps 32 22 2 1 with one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [`MM_DEPTH*`MM_ELEM_W-1:0] rand_row();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = rand_bits(32);
    hi = rand_bits(32);
    return {hi, lo};
  endfunction

  // Expected row sum over the valid depth and zero for rows never loaded
  function automatic acc_t ref_row(input int w);
    int limit;
    int depth;
    int sum;
    limit = (job_rows == 0) ? `MM_W : job_rows;
    depth = (job_cols == 0) ? `MM_DEPTH : job_cols;
    sum   = 0;
    if (w < limit) begin
      for (int k = 0; k < depth; k++) begin
        sum += int'(x_rows[w][k*`MM_ELEM_W +: `MM_ELEM_W]) * job_coef[k % `MM_H];
      end
    end
    return acc_t'(sum);
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Called 1 ns after a rising edge and returns at the same phase
  task automatic run_job(input string name, input int rows, input int cols, input bit stray);
    int limit;
    int gap;
    test_name = name;
    job_rows  = rows;
    job_cols  = cols;
    limit     = (rows == 0) ? `MM_W : rows;
    for (int h = 0; h < `MM_H; h++) begin
      job_coef[h] = int'(rand_bits(8));
      coef_i[h]   = elem_t'(job_coef[h]);
    end
    if (stray) begin
      repeat (2) begin // Dropped while idle
        x_valid_i = 1'b1;
        x_data_i  = rand_row();
        next_cycle();
      end
    end
    start_i   = 1'b1;
    rows_i    = row_cnt_t'(rows);
    cols_i    = depth_cnt_t'(cols);
    x_valid_i = stray;
    x_data_i  = rand_row();
    jobs_started++;
    next_cycle();
    start_i   = 1'b0;
    x_valid_i = 1'b0;
    for (int w = 0; w < limit; w++) begin
      gap = int'(rand_bits(2));
      repeat (gap) next_cycle();
      x_rows[w] = rand_row();
      x_valid_i = 1'b1;
      x_data_i  = x_rows[w];
      next_cycle();
      x_valid_i = 1'b0;
    end
    // Held high through compute when stray strobes are on
    x_valid_i = stray;
    x_data_i  = rand_row();
    do begin
      @(negedge clk_i);
    end while (!done_o);
    next_cycle();
    x_valid_i = 1'b0;
  endtask

  always @(negedge clk_i) begin : check_results
    acc_t exp_z;
    if (rst_ni) begin
      // Busy rises one cycle after start
      if (start_seen) begin
        check_cnt++;
        assert (busy_o) else begin
          error_cnt++;
          $display("mismatch %s busy_o after start: expected 1 actual %0d", test_name,
                   busy_o);
        end
      end
      start_seen = start_i;
      if (done_o) begin
        jobs_done++;
        for (int w = 0; w < `MM_W; w++) begin
          exp_z     = ref_row(w);
          held_z[w] = exp_z;
          check_cnt++;
          assert (z_o[w] == exp_z) else begin
            error_cnt++;
            $display("mismatch %s row %0d: expected %0d actual %0d", test_name, w, exp_z,
                     z_o[w]);
          end
        end
        held_valid = 1'b1;
      end else if (busy_o) begin
        held_valid = 1'b0;
      end else if (held_valid) begin
        for (int w = 0; w < `MM_W; w++) begin
          check_cnt++;
          assert (z_o[w] == held_z[w]) else begin
            error_cnt++;
            $display("mismatch %s hold row %0d: expected %0d actual %0d", test_name, w,
                     held_z[w], z_o[w]);
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("error: run timed out after %0d cycles", cycle_cnt);
      $display("errors: %0d checks: %0d", error_cnt + 1, check_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    start_i      = 1'b0;
    x_valid_i    = 1'b0;
    rows_i       = '0;
    cols_i       = '0;
    x_data_i     = '0;
    coef_i       = '0;
    lfsr_q       = 32'h58b277cb;
    held_valid   = 1'b0;
    start_seen   = 1'b0;
    jobs_started = 0;
    jobs_done    = 0;
    error_cnt    = 0;
    check_cnt    = 0;
    cycle_cnt    = 0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    @(negedge clk_i);
    check_cnt++;
    assert (!busy_o) else begin
      error_cnt++;
      $display("mismatch reset busy_o: expected 0 actual %0d", busy_o);
    end
    check_cnt++;
    assert (!done_o) else begin
      error_cnt++;
      $display("mismatch reset done_o: expected 0 actual %0d", done_o);
    end
    for (int w = 0; w < `MM_W; w++) begin
      check_cnt++;
      assert (z_o[w] == '0) else begin
        error_cnt++;
        $display("mismatch reset row %0d: expected 0 actual %0d", w, z_o[w]);
      end
    end
    next_cycle();

    run_job("full_tile", 0, 0, 1'b0);
    for (int c = 1; c < `MM_DEPTH; c++) run_job("cols_lftovr", 0, c, 1'b0);
    for (int r = 1; r < `MM_W; r++) run_job("rows_lftovr", r, 0, 1'b0);
    run_job("stray_strobes", 0, 0, 1'b1);
    run_job("stray_strobes", 2, 5, 1'b1);
    for (int j = 0; j < 20; j++) begin
      run_job("random", int'(rand_bits(3) % 5), int'(rand_bits(4) % 9), rand_bits(1) != 0);
    end

    repeat (3) next_cycle();
    check_cnt++;
    assert (jobs_done == jobs_started) else begin
      error_cnt++;
      $display("error: %0d jobs started but %0d done pulses seen", jobs_started, jobs_done);
    end
    $display("errors: %0d checks: %0d", error_cnt, check_cnt);
    if (error_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
